// ==== design/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

	// Q16.16 fixed point
	localparam int SAMPLE_W  = 32;
	localparam int FRAC_BITS = 16;

	// transform size and stage count
	localparam int N_POINTS = 8;
	localparam int LOG2_N   = 3;

	// one fixed-point value
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// full width of a product before truncation back to Q16.16
	typedef logic signed [2*SAMPLE_W-1:0] wide_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// real input frame, element 0 in the low bits
	typedef sample_t [N_POINTS-1:0] real_frame_t;

	// complex frame between stages and at the output
	typedef cplx_t [N_POINTS-1:0] cplx_frame_t;

	// cos(2*pi*k/8), k = 0..3
	localparam sample_t TW_COS [N_POINTS/2] = '{
		32'sh00010000,
		32'sh0000b505,
		32'sh00000000,
		32'shffff4afb
	};

	// sin(2*pi*k/8), k = 0..3
	// the butterfly uses cos - j*sin, so these stay positive
	localparam sample_t TW_SIN [N_POINTS/2] = '{
		32'sh00000000,
		32'sh0000b505,
		32'sh00010000,
		32'sh0000b505
	};

endpackage

`default_nettype wire

// ==== design/fft_butterfly.sv ====
`default_nettype none

module fft_butterfly (
	input  wire fft_pkg::cplx_t   a_i,
	input  wire fft_pkg::cplx_t   b_i,
	input  wire fft_pkg::sample_t tw_cos_i,
	input  wire fft_pkg::sample_t tw_sin_i,
	output fft_pkg::cplx_t        upper_o,
	output fft_pkg::cplx_t        lower_o
);

	fft_pkg::sample_t b_re;
	fft_pkg::sample_t b_im;

	// partial products, each at full width
	fft_pkg::wide_t br_wc;
	fft_pkg::wide_t bi_ws;
	fft_pkg::wide_t bi_wc;
	fft_pkg::wide_t br_ws;

	// complex product b * (cos - j*sin)
	fft_pkg::wide_t prod_re;
	fft_pkg::wide_t prod_im;

	// product back in Q16.16
	fft_pkg::wide_t   shr_re;
	fft_pkg::wide_t   shr_im;
	fft_pkg::sample_t t_re;
	fft_pkg::sample_t t_im;

	assign b_re = b_i.re;
	assign b_im = b_i.im;

	// signed operands, sign extended to 64 bits by the context
	assign br_wc = b_re * tw_cos_i;
	assign bi_ws = b_im * tw_sin_i;
	assign bi_wc = b_im * tw_cos_i;
	assign br_ws = b_re * tw_sin_i;

	assign prod_re = br_wc + bi_ws;
	assign prod_im = bi_wc - br_ws;

	// arithmetic shift drops the extra fraction bits
	assign shr_re = prod_re >>> fft_pkg::FRAC_BITS;
	assign shr_im = prod_im >>> fft_pkg::FRAC_BITS;

	// keep the low word, no saturation
	assign t_re = shr_re[fft_pkg::SAMPLE_W-1:0];
	assign t_im = shr_im[fft_pkg::SAMPLE_W-1:0];

	// sum and difference wrap at 32 bits
	always_comb begin
		upper_o.re = a_i.re + t_re;
		upper_o.im = a_i.im + t_im;
		lower_o.re = a_i.re - t_re;
		lower_o.im = a_i.im - t_im;
	end

endmodule

`default_nettype wire

// ==== design/fft_input_reorder.sv ====
`default_nettype none

module fft_input_reorder (
	input  wire                  clk,
	input  wire                  rst_i,
	input  wire                  in_valid_i,
	input  wire fft_pkg::real_frame_t in_frame_i,
	output logic                 valid_o,
	output fft_pkg::cplx_frame_t frame_o
);

	// reverse the LOG2_N low bits of an index
	function automatic int bitrev(input int n);
		int r;
		r = 0;
		for (int b = 0; b < fft_pkg::LOG2_N; b++) begin
			r = (r << 1) | ((n >> b) & 1);
		end
		return r;
	endfunction

	fft_pkg::cplx_frame_t reordered;
	fft_pkg::cplx_frame_t frame_q;
	logic                 valid_q;

	// real samples in bit-reversed slots, imaginary parts left at zero
	always_comb begin
		reordered = '0;
		for (int n = 0; n < fft_pkg::N_POINTS; n++) begin
			reordered[bitrev(n)].re = in_frame_i[n];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid_i;
		end
	end

	// payload only loads with a strobe
	always_ff @(posedge clk) begin
		if (in_valid_i) begin
			frame_q <= reordered;
		end
	end

	assign valid_o = valid_q;
	assign frame_o = frame_q;

endmodule

`default_nettype wire

// ==== design/fft_stage.sv ====
`default_nettype none

module fft_stage #(
	parameter int STAGE = 0
) (
	input  wire                  clk,
	input  wire                  rst_i,
	input  wire                  valid_i,
	input  wire fft_pkg::cplx_frame_t frame_i,
	output logic                 valid_o,
	output fft_pkg::cplx_frame_t frame_o
);

	// distance between the two elements of a pair
	localparam int SPAN = 1 << STAGE;

	// twiddle index step inside a group
	localparam int TW_STEP = fft_pkg::N_POINTS / (2 * SPAN);

	localparam int N_BFLY = fft_pkg::N_POINTS / 2;

	// each butterfly writes two distinct elements of this net
	wire fft_pkg::cplx_frame_t bfly_out;

	fft_pkg::cplx_frame_t frame_q;
	logic                 valid_q;

	for (genvar k = 0; k < N_BFLY; k++) begin : g_bfly
		// group of 2*SPAN elements and position j inside it
		localparam int GRP = k / SPAN;
		localparam int J   = k % SPAN;

		// element j pairs with element j + SPAN
		localparam int UP = GRP * 2 * SPAN + J;
		localparam int LO = UP + SPAN;

		localparam int TW = J * TW_STEP;

		fft_butterfly u_bfly (
			.a_i     (frame_i[UP]),
			.b_i     (frame_i[LO]),
			.tw_cos_i(fft_pkg::TW_COS[TW]),
			.tw_sin_i(fft_pkg::TW_SIN[TW]),
			.upper_o (bfly_out[UP]),
			.lower_o (bfly_out[LO])
		);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= valid_i;
		end
	end

	// all pairs of a frame register together
	always_ff @(posedge clk) begin
		if (valid_i) begin
			frame_q <= bfly_out;
		end
	end

	assign valid_o = valid_q;
	assign frame_o = frame_q;

endmodule

`default_nettype wire

// ==== design/fft_8point.sv ====
`default_nettype none

module fft_8point (
	input  wire                  clk,
	input  wire                  rst_i,
	input  wire                  in_valid_i,
	input  wire fft_pkg::real_frame_t in_frame_i,
	output logic                 out_valid_o,
	output fft_pkg::cplx_frame_t out_frame_o
);

	// index 0 is the reorder register, index s+1 is the output of stage s
	wire [fft_pkg::LOG2_N:0] stage_valid;
	wire fft_pkg::cplx_frame_t stage_frame [fft_pkg::LOG2_N+1];

	fft_input_reorder u_reorder (
		.clk       (clk),
		.rst_i     (rst_i),
		.in_valid_i(in_valid_i),
		.in_frame_i(in_frame_i),
		.valid_o   (stage_valid[0]),
		.frame_o   (stage_frame[0])
	);

	// one registered stage per power of two
	for (genvar s = 0; s < fft_pkg::LOG2_N; s++) begin : g_stage
		fft_stage #(
			.STAGE(s)
		) u_stage (
			.clk    (clk),
			.rst_i  (rst_i),
			.valid_i(stage_valid[s]),
			.frame_i(stage_frame[s]),
			.valid_o(stage_valid[s+1]),
			.frame_o(stage_frame[s+1])
		);
	end

	// last stage drives the outputs directly
	assign out_valid_o = stage_valid[fft_pkg::LOG2_N];
	assign out_frame_o = stage_frame[fft_pkg::LOG2_N];

endmodule

`default_nettype wire

// ==== tb/tb_fft_8point.sv ====
`default_nettype none

module tb_fft_8point;

	localparam int CLK_HALF       = 50;
	localparam int TIMEOUT_CYCLES = 3000;

	// edges from the negedge that drives a strobe to the checker edge seeing the result
	localparam int LATENCY_EDGES = 5;

	// Q16.16 twiddles, cos and sin of 2*pi*k/8
	localparam int TW_COS_TAB [4] = '{
		32'sh00010000,
		32'sh0000b505,
		32'sh00000000,
		32'shffff4afb
	};
	localparam int TW_SIN_TAB [4] = '{
		32'sh00000000,
		32'sh0000b505,
		32'sh00010000,
		32'sh0000b505
	};

	localparam int ONE   = 32'sh00010000;
	localparam int EIGHT = 32'sh00080000;

	typedef struct packed {
		int                   due;
		fft_pkg::cplx_frame_t data;
	} pending_t;

	logic                 clk;
	logic                 rst_i;
	logic                 in_valid_i;
	fft_pkg::real_frame_t in_frame_i;
	logic                 out_valid_o;
	fft_pkg::cplx_frame_t out_frame_o;

	pending_t expect_q [$];

	int cycle_count;
	int frames_sent;
	int frames_dropped;
	int frames_checked;
	int value_errors;
	int flow_errors;
	int seed_val;

	fft_8point uut (
		.clk        (clk),
		.rst_i      (rst_i),
		.in_valid_i (in_valid_i),
		.in_frame_i (in_frame_i),
		.out_valid_o(out_valid_o),
		.out_frame_o(out_frame_o)
	);

	always #CLK_HALF clk = ~clk;

	// three index bits in reverse order
	function automatic int reverse_index(input int n);
		int r;
		r = ((n & 1) << 2) | (n & 2) | ((n >> 2) & 1);
		return r;
	endfunction

	// expected spectrum of one real frame
	function automatic fft_pkg::cplx_frame_t reference_fft(input fft_pkg::real_frame_t x);
		int                   re [8];
		int                   im [8];
		int                   nre [8];
		int                   nim [8];
		int                   span;
		int                   up;
		int                   lo;
		int                   k;
		longint               p_re;
		longint               p_im;
		int                   t_re;
		int                   t_im;
		fft_pkg::cplx_frame_t res;
		for (int n = 0; n < 8; n++) begin
			re[reverse_index(n)] = x[n];
			im[reverse_index(n)] = 0;
		end
		for (int s = 0; s < 3; s++) begin
			span = 1 << s;
			for (int g = 0; g < 8; g += 2 * span) begin
				for (int j = 0; j < span; j++) begin
					up = g + j;
					lo = up + span;
					k  = j * (8 / (2 * span));
					// b times (cos - j*sin), full width before the shift
					p_re = longint'(re[lo]) * longint'(TW_COS_TAB[k])
						+ longint'(im[lo]) * longint'(TW_SIN_TAB[k]);
					p_im = longint'(im[lo]) * longint'(TW_COS_TAB[k])
						- longint'(re[lo]) * longint'(TW_SIN_TAB[k]);
					t_re = int'(p_re >>> 16);
					t_im = int'(p_im >>> 16);
					nre[up] = re[up] + t_re;
					nim[up] = im[up] + t_im;
					nre[lo] = re[up] - t_re;
					nim[lo] = im[up] - t_im;
				end
			end
			re = nre;
			im = nim;
		end
		for (int b = 0; b < 8; b++) begin
			res[b].re = re[b];
			res[b].im = im[b];
		end
		return res;
	endfunction

	// samples in -2^20 .. 2^20
	function automatic fft_pkg::real_frame_t random_frame();
		fft_pkg::real_frame_t f;
		for (int n = 0; n < 8; n++) begin
			f[n] = int'($urandom_range(32'd2097152, 32'd0)) - 1048576;
		end
		return f;
	endfunction

	// one strobe, called on a falling edge
	task automatic send_frame(input fft_pkg::real_frame_t f);
		pending_t p;
		p.due  = cycle_count + LATENCY_EDGES;
		p.data = reference_fft(f);
		expect_q.push_back(p);
		frames_sent++;
		in_valid_i = 1'b1;
		in_frame_i = f;
		@(negedge clk);
		in_valid_i = 1'b0;
	endtask

	// idle cycles with junk on the data bus
	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			in_valid_i = 1'b0;
			in_frame_i = random_frame();
			@(negedge clk);
		end
	endtask

	task automatic compare_bins(input fft_pkg::cplx_frame_t exp_f,
			input fft_pkg::cplx_frame_t act_f);
		for (int b = 0; b < 8; b++) begin
			if (act_f[b].re !== exp_f[b].re) begin
				$display("error at %0t: bin %0d real part expected %h, got %h",
					$time, b, exp_f[b].re, act_f[b].re);
				value_errors++;
			end
			if (act_f[b].im !== exp_f[b].im) begin
				$display("error at %0t: bin %0d imaginary part expected %h, got %h",
					$time, b, exp_f[b].im, act_f[b].im);
				value_errors++;
			end
		end
	endtask

	task automatic run_impulse();
		fft_pkg::real_frame_t f;
		fft_pkg::cplx_frame_t e;
		f    = '0;
		f[0] = ONE;
		e    = reference_fft(f);
		// flat spectrum, worked out by hand
		for (int b = 0; b < 8; b++) begin
			if (e[b].re !== ONE || e[b].im !== 0) begin
				$display("error at %0t: impulse reference bin %0d is %h %h, expected 1.0 and 0",
					$time, b, e[b].re, e[b].im);
				value_errors++;
			end
		end
		send_frame(f);
		idle_cycles(6);
	endtask

	task automatic run_constant();
		fft_pkg::real_frame_t f;
		fft_pkg::cplx_frame_t e;
		for (int n = 0; n < 8; n++) begin
			f[n] = ONE;
		end
		e = reference_fft(f);
		if (e[0].re !== EIGHT || e[0].im !== 0) begin
			$display("error at %0t: constant reference bin 0 is %h %h, expected 8.0 and 0",
				$time, e[0].re, e[0].im);
			value_errors++;
		end
		// other bins at most a truncation residue
		for (int b = 1; b < 8; b++) begin
			if (e[b].re > 16 || e[b].re < -16 || e[b].im > 16 || e[b].im < -16) begin
				$display("error at %0t: constant reference bin %0d is %h %h, expected near 0",
					$time, b, e[b].re, e[b].im);
				value_errors++;
			end
		end
		send_frame(f);
		idle_cycles(6);
	endtask

	task automatic run_back_to_back(input int n);
		for (int i = 0; i < n; i++) begin
			send_frame(random_frame());
		end
		idle_cycles(8);
	endtask

	task automatic run_gapped(input int n);
		for (int i = 0; i < n; i++) begin
			send_frame(random_frame());
			idle_cycles(int'($urandom_range(32'd3, 32'd0)));
		end
		idle_cycles(8);
	endtask

	task automatic run_reset_in_flight();
		repeat (3) begin
			send_frame(random_frame());
		end
		// oldest frame sits in stage 1 here, none has reached the output
		rst_i = 1'b1;
		frames_dropped += expect_q.size();
		expect_q.delete();
		repeat (2) @(negedge clk);
		rst_i = 1'b0;
		idle_cycles(6);
		send_frame(random_frame());
		idle_cycles(6);
	endtask

	// output checker, also the cycle count and the timeout
	always @(posedge clk) begin : output_checker
		pending_t head;
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Testbench failed");
			$finish;
		end else if (cycle_count > 2 && $isunknown(out_valid_o)) begin
			$display("output strobe is unknown at cycle %0d", cycle_count);
			flow_errors++;
		end else if (out_valid_o) begin
			if (expect_q.size() == 0) begin
				$display("an output appeared at cycle %0d with no frame pending", cycle_count);
				flow_errors++;
			end else begin
				head = expect_q.pop_front();
				if (head.due != cycle_count) begin
					$display("an output came at cycle %0d for a frame due at cycle %0d",
						cycle_count, head.due);
					flow_errors++;
				end
				compare_bins(head.data, out_frame_o);
				frames_checked++;
			end
		end else if (expect_q.size() != 0) begin
			if (expect_q[0].due < cycle_count) begin
				$display("a frame due at cycle %0d produced no output", expect_q[0].due);
				flow_errors++;
				head = expect_q.pop_front();
			end
		end
	end

	initial begin
		seed_val       = $urandom(43823);
		clk            = 1'b0;
		rst_i          = 1'b1;
		in_valid_i     = 1'b0;
		in_frame_i     = '0;
		cycle_count    = 0;
		frames_sent    = 0;
		frames_dropped = 0;
		frames_checked = 0;
		value_errors   = 0;
		flow_errors    = 0;

		repeat (2) @(negedge clk);
		rst_i = 1'b0;

		// quiet outputs before the first strobe
		idle_cycles(5);

		run_impulse();
		run_constant();
		run_back_to_back(100);
		run_gapped(50);
		run_reset_in_flight();

		while (expect_q.size() != 0) begin
			@(negedge clk);
		end
		idle_cycles(8);

		if (frames_checked != frames_sent - frames_dropped) begin
			$display("%0d frames were expected at the output but %0d came out",
				frames_sent - frames_dropped, frames_checked);
			flow_errors++;
		end

		$display("frames checked %0d, value errors %0d, flow errors %0d",
			frames_checked, value_errors, flow_errors);
		if (value_errors == 0 && flow_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/fft_pkg.sv
design/fft_butterfly.sv
design/fft_input_reorder.sv
design/fft_stage.sv
design/fft_8point.sv
tb/tb_fft_8point.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -j 0 --top-module tb_fft_8point -f vlog.f --Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qx "Testbench passed" sim.log && exit 0 || exit 1
